// File: Makefile
# Verilator build and run of the matrix multiplier testbench

VERILATOR ?= verilator
TOP       ?= matmul_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT := Verification passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: compile.f
source/matmul_dims_pkg.sv
source/matmul_fixed_pkg.sv
source/a_block_repeat.sv
source/b_weight_buffer.sv
source/block_matmul.sv
source/result_accumulate.sv
source/matmul.sv
test/matmul_tb.sv

// File: source/a_block_repeat.sv
`timescale 1ns/100ps

module a_block_repeat
  import matmul_dims_pkg::*;
  import matmul_fixed_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  in_block_t a_data,
  input  logic      a_valid,
  output logic      a_ready,
  output in_block_t rep_data,
  output logic      rep_valid,
  input  logic      rep_ready
);

  in_block_t held_data;
  logic      held;
  blk_ptr_t  rep_cnt;
  logic      rep_take;
  logic      last_rep;

  assign rep_take = rep_valid && rep_ready;
  assign last_rep = rep_cnt == last_blk;

  // Free to load when empty, or when the final repeat leaves this cycle
  assign a_ready   = !held || (rep_take && last_rep);
  assign rep_valid = held;
  assign rep_data  = held_data;

  always_ff @(posedge clk) begin
    if (rst) begin
      held    <= 1'b0;
      rep_cnt <= '0;
    end else if (a_valid && a_ready) begin
      held    <= 1'b1;
      rep_cnt <= '0;
    end else if (rep_take) begin
      if (last_rep) begin
        held    <= 1'b0;
        rep_cnt <= '0;
      end else begin
        rep_cnt <= rep_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (a_valid && a_ready) begin
      held_data <= a_data;
    end
  end

endmodule

// File: source/b_weight_buffer.sv
`timescale 1ns/100ps

module b_weight_buffer
  import matmul_dims_pkg::*;
  import matmul_fixed_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  in_block_t b_data,
  input  logic      b_valid,
  output logic      b_ready,
  output in_block_t wt_data,
  output logic      wt_valid,
  input  logic      wt_ready
);

  typedef enum logic {
    filling,
    replaying
  } buf_state_t;

  buf_state_t state;
  in_block_t  mem [b_block_count];
  b_addr_t    wr_ptr;
  b_addr_t    rd_ptr;
  // Counts block rows of A served by the current replay
  blk_ptr_t   rep_cnt;
  logic       b_take;
  logic       wt_take;

  assign b_ready  = state == filling;
  assign wt_valid = state == replaying;
  assign wt_data  = mem[rd_ptr];

  assign b_take  = b_valid && b_ready;
  assign wt_take = wt_valid && wt_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= filling;
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      rep_cnt <= '0;
    end else begin
      case (state)
        filling: begin
          if (b_take) begin
            if (wr_ptr == last_b_addr) begin
              wr_ptr <= '0;
              state  <= replaying;
            end else begin
              wr_ptr <= wr_ptr + 1'b1;
            end
          end
        end
        replaying: begin
          if (wt_take) begin
            if (rd_ptr == last_b_addr) begin
              rd_ptr <= '0;
              // Whole B sent once per block row of A
              if (rep_cnt == last_blk) begin
                rep_cnt <= '0;
                state   <= filling;
              end else begin
                rep_cnt <= rep_cnt + 1'b1;
              end
            end else begin
              rd_ptr <= rd_ptr + 1'b1;
            end
          end
        end
        default: state <= filling;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (b_take) begin
      mem[wr_ptr] <= b_data;
    end
  end

  // Replay starts on the cycle after the last B block lands, from the first block
  assert property (@(posedge clk) disable iff (rst)
    b_take && wr_ptr == last_b_addr |=> wt_valid && rd_ptr == '0);

endmodule

// File: source/block_matmul.sv
`timescale 1ns/100ps

module block_matmul
  import matmul_dims_pkg::*;
  import matmul_fixed_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  in_block_t   rep_data,
  input  logic        rep_valid,
  output logic        rep_ready,
  input  in_block_t   wt_data,
  input  logic        wt_valid,
  output logic        wt_ready,
  output prod_block_t prod_data,
  input  logic        prod_ready,
  output logic        prod_valid
);

  prod_block_t next_prod;
  logic        out_full;
  logic        out_free;
  logic        take;

  // Output register can take a new product when empty or draining
  assign out_free = !out_full || prod_ready;

  // Each side is ready only when the other side has data too
  assign rep_ready = wt_valid && out_free;
  assign wt_ready  = rep_valid && out_free;
  assign take      = rep_valid && wt_valid && out_free;

  assign prod_valid = out_full;

  // C(r,c) = sum over m of A(r,m) * B(m,c), full precision
  always_comb begin
    prod_elem_t sum;
    in_elem_t   a_e;
    in_elem_t   b_e;
    next_prod = '0;
    for (int r = 0; r < block_dim; r++) begin
      for (int c = 0; c < block_dim; c++) begin
        sum = '0;
        for (int m = 0; m < block_dim; m++) begin
          a_e = rep_data[(r * block_dim + m) * in_width +: in_width];
          b_e = wt_data[(m * block_dim + c) * in_width +: in_width];
          sum = sum + a_e * b_e;
        end
        next_prod[(r * block_dim + c) * prod_width +: prod_width] = sum;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_full <= 1'b0;
    end else if (take) begin
      out_full <= 1'b1;
    end else if (prod_ready) begin
      out_full <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      prod_data <= next_prod;
    end
  end

  // A stalled product holds until the accumulator takes it
  assert property (@(posedge clk) disable iff (rst)
    prod_valid && !prod_ready |=> prod_valid && $stable(prod_data));

endmodule

// File: source/matmul.sv
`timescale 1ns/100ps

module matmul
  import matmul_fixed_pkg::*;
(
  input  logic       clk,
  input  logic       rst,

  // A blocks, row-major within a block
  input  in_block_t  a_data,
  input  logic       a_valid,
  output logic       a_ready,

  // B blocks, stored then replayed
  input  in_block_t  b_data,
  input  logic       b_valid,
  output logic       b_ready,

  // C blocks, block row then block column
  output out_block_t c_data,
  output logic       c_valid,
  input  logic       c_ready
);

  in_block_t   rep_data;
  logic        rep_valid;
  logic        rep_ready;

  in_block_t   wt_data;
  logic        wt_valid;
  logic        wt_ready;

  prod_block_t prod_data;
  logic        prod_valid;
  logic        prod_ready;

  a_block_repeat a_block_repeat_inst (
    .clk       (clk),
    .rst       (rst),
    .a_data    (a_data),
    .a_valid   (a_valid),
    .a_ready   (a_ready),
    .rep_data  (rep_data),
    .rep_valid (rep_valid),
    .rep_ready (rep_ready)
  );

  b_weight_buffer b_weight_buffer_inst (
    .clk      (clk),
    .rst      (rst),
    .b_data   (b_data),
    .b_valid  (b_valid),
    .b_ready  (b_ready),
    .wt_data  (wt_data),
    .wt_valid (wt_valid),
    .wt_ready (wt_ready)
  );

  block_matmul block_matmul_inst (
    .clk        (clk),
    .rst        (rst),
    .rep_data   (rep_data),
    .rep_valid  (rep_valid),
    .rep_ready  (rep_ready),
    .wt_data    (wt_data),
    .wt_valid   (wt_valid),
    .wt_ready   (wt_ready),
    .prod_data  (prod_data),
    .prod_ready (prod_ready),
    .prod_valid (prod_valid)
  );

  result_accumulate result_accumulate_inst (
    .clk        (clk),
    .rst        (rst),
    .prod_data  (prod_data),
    .prod_valid (prod_valid),
    .prod_ready (prod_ready),
    .c_data     (c_data),
    .c_valid    (c_valid),
    .c_ready    (c_ready)
  );

endmodule

// File: source/matmul_dims_pkg.sv
package matmul_dims_pkg;

  // Square operands, cut into square blocks
  localparam int total_dim = 4;
  localparam int block_dim = 2;

  // Blocks along one side of a matrix
  localparam int block_depth = total_dim / block_dim;

  // Elements carried in one block transfer
  localparam int block_elems = block_dim * block_dim;

  // B is held whole while A streams past it
  localparam int b_block_count = block_depth * block_depth;
  localparam int b_addr_width = $clog2(b_block_count);

  // Picks one block position along a matrix side
  typedef logic [$clog2(block_depth)-1:0] blk_ptr_t;

  // Address into the stored B blocks
  typedef logic [b_addr_width-1:0] b_addr_t;

  // Last repeat, last accumulator, last shared index
  localparam blk_ptr_t last_blk = blk_ptr_t'(block_depth - 1);

  localparam b_addr_t last_b_addr = b_addr_t'(b_block_count - 1);

endpackage

// File: source/matmul_fixed_pkg.sv
package matmul_fixed_pkg;

  import matmul_dims_pkg::*;

  // Input elements, same format for A and B
  localparam int in_width = 8;
  localparam int in_frac = 1;

  // Dot product over one block row grows by one bit per doubling of terms
  localparam int prod_width = 2 * in_width + $clog2(block_dim);
  localparam int prod_frac = 2 * in_frac;

  // Summing block_depth partial products
  localparam int acc_width = prod_width + $clog2(block_depth);

  // Output elements
  localparam int out_width = 16;
  localparam int out_frac = 2;

  typedef logic signed [in_width-1:0] in_elem_t;
  typedef logic signed [prod_width-1:0] prod_elem_t;
  typedef logic signed [acc_width-1:0] acc_elem_t;
  typedef logic signed [out_width-1:0] out_elem_t;

  // Row-major blocks, element 0 in the low bits
  typedef logic [block_elems*in_width-1:0] in_block_t;
  typedef logic [block_elems*prod_width-1:0] prod_block_t;
  typedef logic [block_elems*out_width-1:0] out_block_t;

  // Saturation bounds of the output format, held at accumulator width
  localparam acc_elem_t out_max = acc_elem_t'((1 <<< (out_width - 1)) - 1);
  localparam acc_elem_t out_min = acc_elem_t'(-(1 <<< (out_width - 1)));

endpackage

// File: source/result_accumulate.sv
`timescale 1ns/100ps

module result_accumulate
  import matmul_dims_pkg::*;
  import matmul_fixed_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  prod_block_t prod_data,
  input  logic        prod_valid,
  output logic        prod_ready,
  output out_block_t  c_data,
  output logic        c_valid,
  input  logic        c_ready
);

  // One accumulator per block column of C
  acc_elem_t acc_sum [block_depth][block_elems];
  acc_elem_t acc_next [block_elems];
  blk_ptr_t  in_cnt [block_depth];
  logic [block_depth-1:0] full;

  blk_ptr_t in_ptr;
  blk_ptr_t out_ptr;
  logic     prod_take;
  logic     c_take;

  function automatic out_elem_t saturate(acc_elem_t value);
    acc_elem_t scaled;
    // Shift is zero here since prod_frac matches out_frac
    scaled = value >>> (prod_frac - out_frac);
    if (scaled > out_max) begin
      return out_elem_t'(out_max);
    end else if (scaled < out_min) begin
      return out_elem_t'(out_min);
    end
    return out_elem_t'(scaled);
  endfunction

  assign prod_ready = !full[in_ptr];
  assign prod_take  = prod_valid && prod_ready;

  assign c_valid = full[out_ptr];
  assign c_take  = c_valid && c_ready;

  // First partial product of a block starts a fresh sum
  always_comb begin
    for (int e = 0; e < block_elems; e++) begin
      if (in_cnt[in_ptr] == '0) begin
        acc_next[e] = prod_elem_t'(prod_data[e * prod_width +: prod_width]);
      end else begin
        acc_next[e] = acc_sum[in_ptr][e]
                    + prod_elem_t'(prod_data[e * prod_width +: prod_width]);
      end
    end
  end

  always_comb begin
    for (int e = 0; e < block_elems; e++) begin
      c_data[e * out_width +: out_width] = saturate(acc_sum[out_ptr][e]);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      in_ptr  <= '0;
      out_ptr <= '0;
      full    <= '0;
      in_cnt  <= '{default: '0};
    end else begin
      if (prod_take) begin
        in_ptr <= (in_ptr == last_blk) ? '0 : in_ptr + 1'b1;
        // Second shared index completes the block
        if (in_cnt[in_ptr] == last_blk) begin
          in_cnt[in_ptr] <= '0;
          full[in_ptr]   <= 1'b1;
        end else begin
          in_cnt[in_ptr] <= in_cnt[in_ptr] + 1'b1;
        end
      end
      if (c_take) begin
        full[out_ptr] <= 1'b0;
        out_ptr       <= (out_ptr == last_blk) ? '0 : out_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (prod_take) begin
      acc_sum[in_ptr] <= acc_next;
    end
  end

  // Output block holds still under back-pressure
  assert property (@(posedge clk) disable iff (rst)
    c_valid && !c_ready |=> c_valid && $stable(c_data));

endmodule

// File: test/matmul_tb.sv
`timescale 1ns/100ps

module matmul_tb
  import matmul_dims_pkg::*;
  import matmul_fixed_pkg::*;
;

  typedef in_elem_t mat_t [total_dim][total_dim];

  localparam int wait_limit = 2000;
  localparam int max_runs = 2;

  logic       clk;
  logic       rst;
  in_block_t  a_data;
  logic       a_valid;
  logic       a_ready;
  in_block_t  b_data;
  logic       b_valid;
  logic       b_ready;
  out_block_t c_data;
  logic       c_valid;
  logic       c_ready;

  mat_t mat_a [max_runs];
  mat_t mat_b [max_runs];

  out_block_t exp_q [$];
  int received;
  int errors;
  int checks;
  int tests_run;
  int tests_failed;
  int a_runs_done;
  bit hung;

  matmul matmul_inst (
    .clk     (clk),
    .rst     (rst),
    .a_data  (a_data),
    .a_valid (a_valid),
    .a_ready (a_ready),
    .b_data  (b_data),
    .b_valid (b_valid),
    .b_ready (b_ready),
    .c_data  (c_data),
    .c_valid (c_valid),
    .c_ready (c_ready)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Exact integer product, clamped to the C format, blocks in row then column order
  function automatic void ref_matmul(input mat_t a, input mat_t b,
                                     output out_block_t c_blk [b_block_count]);
    int sum;
    int clipped;
    int idx;
    int pos;
    for (int n = 0; n < b_block_count; n++) begin
      c_blk[n] = '0;
    end
    for (int i = 0; i < total_dim; i++) begin
      for (int j = 0; j < total_dim; j++) begin
        sum = 0;
        for (int k = 0; k < total_dim; k++) begin
          sum = sum + int'(a[i][k]) * int'(b[k][j]);
        end
        clipped = (sum > 32767) ? 32767 : ((sum < -32768) ? -32768 : sum);
        idx = (i / block_dim) * block_depth + (j / block_dim);
        pos = (i % block_dim) * block_dim + (j % block_dim);
        c_blk[idx][pos * out_width +: out_width] = out_elem_t'(clipped);
      end
    end
  endfunction

  function automatic in_block_t pack_block(input mat_t m, input int br, input int bc);
    in_block_t blk;
    blk = '0;
    for (int r = 0; r < block_dim; r++) begin
      for (int c = 0; c < block_dim; c++) begin
        blk[(r * block_dim + c) * in_width +: in_width] =
          m[br * block_dim + r][bc * block_dim + c];
      end
    end
    return blk;
  endfunction

  function automatic void fill_random(output mat_t m);
    for (int i = 0; i < total_dim; i++) begin
      for (int j = 0; j < total_dim; j++) begin
        m[i][j] = in_elem_t'($urandom);
      end
    end
  endfunction

  function automatic void fill_const(output mat_t m, input in_elem_t v);
    for (int i = 0; i < total_dim; i++) begin
      for (int j = 0; j < total_dim; j++) begin
        m[i][j] = v;
      end
    end
  endfunction

  // Diagonal of 1.0, which is raw 2 with one fraction bit
  function automatic void fill_identity(output mat_t m);
    for (int i = 0; i < total_dim; i++) begin
      for (int j = 0; j < total_dim; j++) begin
        m[i][j] = (i == j) ? in_elem_t'(2) : in_elem_t'(0);
      end
    end
  endfunction

  task automatic flag_hang(input string what);
    hung = 1'b1;
    errors++;
    $display("Timeout after %0d cycles: %s", wait_limit, what);
  endtask

  // Called 1 ns after a rising edge, returns 1 ns after the edge that took the block
  task automatic send_a_block(input in_block_t blk);
    int waited;
    waited = 0;
    a_data = blk;
    a_valid = 1'b1;
    @(negedge clk);
    while (!a_ready && !hung) begin
      if (waited >= wait_limit) begin
        flag_hang("A block was never accepted");
      end else begin
        waited++;
        @(negedge clk);
      end
    end
    @(posedge clk);
    #1;
    a_valid = 1'b0;
  endtask

  task automatic send_b_block(input in_block_t blk);
    int waited;
    waited = 0;
    b_data = blk;
    b_valid = 1'b1;
    @(negedge clk);
    while (!b_ready && !hung) begin
      if (waited >= wait_limit) begin
        flag_hang("B block was never accepted");
      end else begin
        waited++;
        @(negedge clk);
      end
    end
    @(posedge clk);
    #1;
    b_valid = 1'b0;
  endtask

  task automatic send_a_matrix(input int run);
    for (int bi = 0; bi < block_depth; bi++) begin
      for (int bk = 0; bk < block_depth; bk++) begin
        send_a_block(pack_block(mat_a[run], bi, bk));
      end
    end
    a_runs_done++;
  endtask

  task automatic send_b_matrix(input int run);
    for (int bk = 0; bk < block_depth; bk++) begin
      for (int bj = 0; bj < block_depth; bj++) begin
        send_b_block(pack_block(mat_b[run], bk, bj));
        // A new B may only land once the previous A matrix has been taken
        if (run > 0 && bk == 0 && bj == 0 && !hung) begin
          assert (a_runs_done >= run) else begin
            errors++;
            $display("B of run %0d was accepted before A of run %0d was taken", run, run - 1);
          end
        end
      end
    end
  endtask

  // Drives c_ready each cycle until all expected C blocks have left
  task automatic pace_output(input int target, input bit toggle);
    int waited;
    waited = 0;
    while (received < target && !hung) begin
      if (waited >= wait_limit) begin
        flag_hang("C blocks stopped arriving");
      end else begin
        c_ready = toggle ? 1'($urandom & 1) : 1'b1;
        @(posedge clk);
        #1;
        waited++;
      end
    end
    c_ready = 1'b1;
  endtask

  task automatic run_test(input string name, input int runs, input bit toggle);
    out_block_t expected [b_block_count];
    int errors_before;
    int target;
    errors_before = errors;
    exp_q.delete();
    received = 0;
    a_runs_done = 0;
    for (int r = 0; r < runs; r++) begin
      ref_matmul(mat_a[r], mat_b[r], expected);
      for (int n = 0; n < b_block_count; n++) begin
        exp_q.push_back(expected[n]);
      end
    end
    target = runs * b_block_count;
    fork
      for (int r = 0; r < runs; r++) begin
        send_b_matrix(r);
      end
      for (int r = 0; r < runs; r++) begin
        send_a_matrix(r);
      end
      pace_output(target, toggle);
    join
    if (!hung) begin
      assert (received == target && exp_q.size() == 0) else begin
        errors++;
        $display("%s: received %0d C blocks, %0d still expected", name, received, exp_q.size());
      end
    end
    tests_run++;
    if (errors == errors_before) begin
      $display("PASS %s: %0d C blocks checked", name, target);
    end else begin
      tests_failed++;
      $display("FAIL %s: %0d errors", name, errors - errors_before);
    end
  endtask

  // Output checker, samples mid-cycle and compares each accepted C block
  always @(negedge clk) begin
    out_block_t exp;
    if (!rst && c_valid && c_ready) begin
      assert (exp_q.size() > 0) else begin
        errors++;
        $display("Unexpected C block %h arrived with none expected", c_data);
      end
      if (exp_q.size() > 0) begin
        exp = exp_q.pop_front();
        checks++;
        assert (c_data == exp) else begin
          errors++;
          $display("MISMATCH c_data block %0d: expected %h, got %h", received, exp, c_data);
        end
      end
      received++;
    end
  end

  initial begin
    void'($urandom(79561));
    rst = 1'b1;
    a_data = '0;
    a_valid = 1'b0;
    b_data = '0;
    b_valid = 1'b0;
    c_ready = 1'b1;
    errors = 0;
    checks = 0;
    tests_run = 0;
    tests_failed = 0;
    received = 0;
    a_runs_done = 0;
    hung = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;

    fill_random(mat_a[0]);
    fill_identity(mat_b[0]);
    if (!hung) run_test("identity_weights", 1, 1'b0);

    // Same operands for the free-running and the stalled case
    fill_random(mat_a[0]);
    fill_random(mat_b[0]);
    if (!hung) run_test("random_matrices", 1, 1'b0);
    if (!hung) run_test("back_pressure", 1, 1'b1);

    fill_const(mat_a[0], in_elem_t'(-128));
    fill_const(mat_b[0], in_elem_t'(-128));
    if (!hung) run_test("saturate_positive", 1, 1'b0);
    fill_const(mat_b[0], in_elem_t'(127));
    if (!hung) run_test("saturate_negative", 1, 1'b0);

    fill_random(mat_a[0]);
    fill_random(mat_b[0]);
    fill_random(mat_a[1]);
    fill_random(mat_b[1]);
    if (!hung) run_test("back_to_back", 2, 1'b0);

    $display("Tests run %0d, failed %0d, block checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0 && !hung) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule
